/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= icache_tb
FILELIST  ?= icache_top.f
OBJ_DIR   ?= obj_dir

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* bench/icache_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

// Handshake and reset properties, bound into icache_top
module icache_assertions
    import l2_pkg::*;
(
    input wire logic     CLK,
    input wire logic     arst_n,
    input wire logic     proc_ready,
    input wire logic     data_valid,
    input wire logic     l2_addr_valid,
    input wire logic     l2_addr_ready,
    input wire l2_addr_t l2_addr
);

    // Address held while L2 stalls the request
    a_addr_stable: assert property (@(posedge CLK) disable iff (!arst_n)
        (l2_addr_valid && !l2_addr_ready) |=> (l2_addr_valid && $stable(l2_addr)))
        else $error("l2_addr changed before L2 accepted it");

    // Frozen processor sees no data
    a_dv_ready: assert property (@(posedge CLK) disable iff (!arst_n)
        data_valid |-> proc_ready)
        else $error("data_valid high while proc_ready low");

    a_reset_quiet: assert property (@(posedge CLK)
        !arst_n |=> (!l2_addr_valid && !data_valid))   // Outputs quiet once reset applied
        else $error("valid output high during reset");

endmodule

`default_nettype wire

/* bench/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_tb
    import icache_pkg::*;
    import l2_pkg::*;
;

    localparam int NUM_DELIVER = 800;       // Words checked before the end
    localparam int MAX_CYCLES  = 100000;
    localparam int WAIT_LIMIT  = 2000;      // Per wait loop
    localparam int CALM_COUNT  = 64;        // No stalls or branches at first

    logic     CLK;
    logic     arst_n;
    logic     proc_ready;
    logic     branch;
    pc_t      branch_addr;
    logic     cache_ready;
    logic     data_valid;
    word_t    data_to_proc;
    pc_t      pc_to_proc;
    logic     l2_addr_valid;
    logic     l2_addr_ready;
    l2_addr_t l2_addr;
    logic     l2_data_valid;
    logic     l2_data_ready;
    l2_data_t l2_data;

    // Scoreboard state, written by the monitor
    logic [31:0] rng_stim = 32'h8ab9_d133;
    logic [31:0] rng_l2;
    pc_t         last_pc = `ICACHE_RESET_PC - 4;
    pc_t         target_q[$];               // Accepted branch targets
    int          since_branch = 0;
    int          deliveries   = 0;
    int          req_count    = 0;
    int          exp_misses   = 0;
    int          beat_count   = 0;
    int          revisits     = 0;
    logic        outstanding  = 1'b0;
    logic        br_taken     = 1'b0;
    l2_addr_t    last_req     = '0;
    l2_addr_t    model_line [1 << `ICACHE_INDEX_W];   // Resident line per index
    logic        model_vld  [1 << `ICACHE_INDEX_W] = '{default: 1'b0};

    icache_top i_dut (.*);

    bind icache_top icache_assertions u_assert (.*);

    //////////////////////////////////////////////////////////////////////
    // Reference model and checks
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Memory content, word at a word address
    function automatic word_t ref_word(input pc_t addr);
        return xorshift(addr >> 2);
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            report_failure("Word mismatch");
        end
    endtask

    task automatic check_pc(input string name, input pc_t exp, input pc_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            report_failure("PC mismatch");
        end
    endtask

    task automatic check_line(input string name, input l2_addr_t exp, input l2_addr_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            report_failure("L2 line address mismatch");
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            report_failure("L2 request count mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            report_failure("Control signal mismatch");
        end
    endtask

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    //////////////////////////////////////////////////////////////////////
    // Monitor, samples pre-edge values
    //////////////////////////////////////////////////////////////////////

    always @(posedge CLK) begin : monitor
        l2_addr_t line;
        logic [`ICACHE_INDEX_W-1:0] idx;
        if (arst_n) begin
            if (data_valid) begin
                if (!proc_ready)
                    report_failure("data_valid high while proc_ready low");
                line = pc_to_proc[31 -: L2_ADDR_W];
                idx  = line[`ICACHE_INDEX_W-1:0];
                if (target_q.size() > 0 && pc_to_proc == target_q[0]) begin
                    if (model_vld[idx] && model_line[idx] == line)
                        revisits++;                 // Branch into a filled line
                    void'(target_q.pop_front());
                    since_branch = 0;
                end else begin
                    check_pc("pc sequence", last_pc + 4, pc_to_proc);
                    if (target_q.size() > 0) begin
                        since_branch++;             // Older PCs still in flight
                        if (since_branch > 4)
                            report_failure("Branch target was not delivered in time");
                    end
                end
                check_word("instruction word", ref_word(pc_to_proc), data_to_proc);
                // New line for this index means one more L2 request
                if (!model_vld[idx] || model_line[idx] != line) begin
                    exp_misses++;
                    model_vld[idx]  = 1'b1;
                    model_line[idx] = line;
                    check_line("request line", line, last_req);
                end
                check_count("l2 requests", exp_misses, req_count);
                last_pc = pc_to_proc;
                deliveries++;
            end
            br_taken = branch && proc_ready && cache_ready;
            if (br_taken) begin
                target_q.push_back(branch_addr);
                since_branch = 0;
            end
            if (l2_addr_valid && outstanding)
                report_failure("Second L2 request while one is outstanding");
            if (l2_data_ready && !outstanding)
                report_failure("l2_data_ready high with no line request outstanding");
            if (cache_ready && outstanding)
                report_failure("cache_ready high while a line refill is outstanding");
            if (l2_addr_valid && l2_addr_ready) begin
                outstanding = 1'b1;
                req_count++;
                last_req = l2_addr;
            end
            if (l2_data_valid && l2_data_ready) begin
                beat_count++;
                if (beat_count % L2_BEATS == 0)
                    outstanding = 1'b0;             // Line complete
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // L2 responder, one line at a time
    //////////////////////////////////////////////////////////////////////

    initial begin : l2_responder
        int       wait_cnt;
        int       gap;
        int       seen;
        l2_addr_t addr;
        l2_addr_ready = 1'b0;
        l2_data_valid = 1'b0;
        l2_data       = '0;
        rng_l2        = xorshift(32'h8ab9_d133);
        @(posedge arst_n);
        forever begin
            wait_cnt = 0;
            @(negedge CLK);
            while (!l2_addr_valid) begin
                @(negedge CLK);
                wait_cnt++;
                if (wait_cnt > WAIT_LIMIT)
                    report_failure("Timeout waiting for an L2 request");
            end
            seen     = req_count;
            wait_cnt = 0;
            while (req_count == seen) begin
                rng_l2 = xorshift(rng_l2);
                l2_addr_ready = (deliveries < CALM_COUNT) || (rng_l2[1:0] != 2'b00);
                @(negedge CLK);
                wait_cnt++;
                if (wait_cnt > WAIT_LIMIT)
                    report_failure("Timeout waiting for the L2 address handshake");
            end
            l2_addr_ready = 1'b0;
            addr = last_req;
            for (int b = 0; b < L2_BEATS; b++) begin
                rng_l2 = xorshift(rng_l2);
                gap = (deliveries < CALM_COUNT) ? 0 : int'(rng_l2[1:0]);
                repeat (gap) @(negedge CLK);        // Random beat gap
                l2_data_valid = 1'b1;
                l2_data  = ref_word({addr, b[1:0], 2'b00});
                seen     = beat_count;
                wait_cnt = 0;
                while (beat_count == seen) begin
                    @(negedge CLK);
                    wait_cnt++;
                    if (wait_cnt > WAIT_LIMIT)
                        report_failure("Timeout waiting for l2_data_ready");
                end
                l2_data_valid = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Processor stimulus, driven on the falling edge
    //////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        int  cycles;
        int  diff;
        pc_t target;
        arst_n      = 1'b0;
        proc_ready  = 1'b0;
        branch      = 1'b0;
        branch_addr = '0;
        repeat (10) begin
            @(negedge CLK);
            check_flag("reset data_valid", 1'b0, data_valid);
            check_flag("reset l2_addr_valid", 1'b0, l2_addr_valid);
        end
        arst_n = 1'b1;
        @(negedge CLK);
        check_flag("post-reset data_valid", 1'b0, data_valid);
        check_flag("post-reset l2_addr_valid", 1'b0, l2_addr_valid);
        check_flag("post-reset l2_data_ready", 1'b0, l2_data_ready);
        check_flag("post-reset cache_ready", 1'b1, cache_ready);
        cycles = 0;
        while (deliveries < NUM_DELIVER) begin
            rng_stim   = xorshift(rng_stim);
            proc_ready = (deliveries < CALM_COUNT) || (rng_stim[2:0] != 3'b000);
            if (branch && br_taken) begin
                branch = 1'b0;                      // Accepted on last edge
            end else if (deliveries >= CALM_COUNT && !branch && target_q.size() == 0
                         && rng_stim[12:8] == 5'd0) begin
                target = 32'h100 + {rng_stim[24:16], 2'b00};   // 2 KiB region
                diff   = int'(target) - int'(last_pc);
                // Keep clear of PCs still in flight
                if (diff < -16 || diff > 32) begin
                    branch      = 1'b1;
                    branch_addr = target;
                end
            end
            @(negedge CLK);
            cycles++;
            if (cycles > MAX_CYCLES)
                report_failure("Timeout waiting for delivered words");
        end
        if (revisits == 0) begin
            report_failure("No branch target hit a filled line");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* common/icache_params.svh */
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Processor side, byte address and instruction word
`define ICACHE_ADDR_W      32
`define ICACHE_WORD_W      32

// First fetch address after reset
`define ICACHE_RESET_PC    32'h0000_0100

// Cache geometry, 64 lines of 4 words
`define ICACHE_INDEX_W     6
`define ICACHE_LINE_WORDS  4

// L2 data bus, one beat per transfer
`define ICACHE_L2_W        32

`endif

/* common/icache_pkg.sv */
`default_nettype none

`include "icache_params.svh"

package icache_pkg;

    // Address split, low to high is byte, offset, index, tag
    localparam int BYTE_W   = $clog2(`ICACHE_WORD_W / 8);
    localparam int OFFSET_W = $clog2(`ICACHE_LINE_WORDS);
    localparam int TAG_W    = `ICACHE_ADDR_W - `ICACHE_INDEX_W - OFFSET_W - BYTE_W;

    typedef logic [`ICACHE_ADDR_W-1:0]                      pc_t;
    typedef logic [`ICACHE_WORD_W-1:0]                      word_t;
    typedef logic [TAG_W-1:0]                               tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]                     index_t;
    typedef logic [OFFSET_W-1:0]                            offset_t;
    typedef logic [`ICACHE_LINE_WORDS*`ICACHE_WORD_W-1:0]   line_t;

    typedef enum logic [1:0] {
        LK_RUN,     // Pipeline flowing
        LK_WAIT,    // Miss sent, waiting for the line
        LK_REPLAY   // Re-read stores for the missed PC
    } lookup_state_t;

    function automatic tag_t pc_tag(pc_t pc);
        return pc[`ICACHE_ADDR_W-1 -: TAG_W];
    endfunction

    function automatic index_t pc_index(pc_t pc);
        return pc[BYTE_W+OFFSET_W +: `ICACHE_INDEX_W];
    endfunction

    function automatic offset_t pc_offset(pc_t pc);
        return pc[BYTE_W +: OFFSET_W];
    endfunction

endpackage

`default_nettype wire

/* common/l2_pkg.sv */
`default_nettype none

`include "icache_params.svh"

package l2_pkg;

    // Beats per line, and line address width (word offset dropped)
    localparam int L2_BEATS  = `ICACHE_LINE_WORDS * `ICACHE_WORD_W / `ICACHE_L2_W;
    localparam int L2_ADDR_W = `ICACHE_ADDR_W
                             - $clog2(`ICACHE_LINE_WORDS * `ICACHE_WORD_W / 8);

    typedef logic [L2_ADDR_W-1:0]         l2_addr_t;   // {tag, index}
    typedef logic [`ICACHE_L2_W-1:0]      l2_data_t;
    typedef logic [$clog2(L2_BEATS)-1:0]  beat_cnt_t;

    typedef enum logic [1:0] {
        IDLE,       // No miss pending
        REQUEST,    // Line address offered to L2
        COLLECT,    // Beats coming back
        WRITE       // Line handed to lookup
    } refill_state_t;

endpackage

`default_nettype wire

/* common/line_fill_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Finished cache line, refill to lookup
interface line_fill_if
    import icache_pkg::*;
    import l2_pkg::*;
();

    logic                     wr;       // Single-cycle strobe, always taken
    index_t                   index;    // Line slot to write
    tag_t                     tag;      // Tag stored with it
    l2_data_t [L2_BEATS-1:0]  line;     // Beat 0 sits in the low word

    // Refill side drives
    modport src (output wr, index, tag, line);

    // Lookup side receives
    modport dst (input wr, index, tag, line);

endinterface

`default_nettype wire

/* hdl/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top
    import icache_pkg::*;
    import l2_pkg::*;
(
    input  logic     CLK,
    input  logic     arst_n,
    // Processor side
    input  logic     proc_ready,      // Global freeze when low
    input  logic     branch,
    input  pc_t      branch_addr,
    output logic     cache_ready,
    output logic     data_valid,
    output word_t    data_to_proc,
    output pc_t      pc_to_proc,
    // L2 address channel
    output logic     l2_addr_valid,
    input  logic     l2_addr_ready,
    output l2_addr_t l2_addr,
    // L2 data channel
    input  logic     l2_data_valid,
    output logic     l2_data_ready,
    input  l2_data_t l2_data
);

    logic miss;         // One-cycle miss strobe
    pc_t  miss_pc;      // PC that missed in stage 2

    line_fill_if fill ();

    // Data path
    icache_lookup u_lookup (
        .CLK          (CLK),
        .arst_n       (arst_n),
        .proc_ready   (proc_ready),
        .branch       (branch),
        .branch_addr  (branch_addr),
        .cache_ready  (cache_ready),
        .data_valid   (data_valid),
        .data_to_proc (data_to_proc),
        .pc_to_proc   (pc_to_proc),
        .miss         (miss),
        .miss_pc      (miss_pc),
        .fill         (fill)
    );

    // Refill path
    icache_refill u_refill (
        .CLK           (CLK),
        .arst_n        (arst_n),
        .miss          (miss),
        .miss_pc       (miss_pc),
        .l2_addr_valid (l2_addr_valid),
        .l2_addr_ready (l2_addr_ready),
        .l2_addr       (l2_addr),
        .l2_data_valid (l2_data_valid),
        .l2_data_ready (l2_data_ready),
        .l2_data       (l2_data),
        .fill          (fill)
    );

endmodule

`default_nettype wire

/* icache_top.f */
+incdir+common
common/icache_pkg.sv
common/l2_pkg.sv
common/line_fill_if.sv
lookup/icache_lookup.sv
refill/icache_refill.sv
hdl/icache_top.sv
bench/icache_assertions.sv
bench/icache_tb.sv

/* lookup/icache_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_lookup
    import icache_pkg::*;
(
    input  logic     CLK,
    input  logic     arst_n,
    input  logic     proc_ready,
    input  logic     branch,
    input  pc_t      branch_addr,
    output logic     cache_ready,
    output logic     data_valid,
    output word_t    data_to_proc,
    output pc_t      pc_to_proc,
    output logic     miss,
    output pc_t      miss_pc,
    line_fill_if.dst fill
);

    localparam int LINES = 1 << `ICACHE_INDEX_W;

    lookup_state_t state;
    pc_t           pc;              // Stage 1, store read address
    pc_t           pc_d1;           // Stage 2, tag compare
    pc_t           next_pc;
    logic          s2_vld;          // Stage 2 holds a real PC
    logic          dv_q;            // Output register loaded
    logic          s2_hit;
    logic          s2_miss;
    logic          advance;         // Pipeline moves this edge
    logic          rd_en;
    index_t        rd_index;

    // Tag and line stores, one way
    tag_t          tag_mem  [LINES];
    line_t         line_mem [LINES];
    logic [LINES-1:0] valid_q;

    // Registered store outputs
    tag_t          tag_rd;
    line_t         line_rd;
    logic          valid_rd;
    word_t [`ICACHE_LINE_WORDS-1:0] s2_words;

    //////////////////////////////////////////////////////////////////////
    // Hit detection and pipeline control
    //////////////////////////////////////////////////////////////////////

    assign s2_hit      = s2_vld & valid_rd & (tag_rd == pc_tag(pc_d1));
    assign s2_miss     = (state == LK_RUN) & s2_vld & ~s2_hit;
    assign cache_ready = (state == LK_RUN) & ~s2_miss;   // Drops with the miss
    assign advance     = proc_ready & cache_ready;
    assign miss        = proc_ready & s2_miss;           // Once, state leaves RUN
    assign miss_pc     = pc_d1;                          // Held until replay
    assign data_valid  = dv_q & proc_ready;

    assign next_pc = branch ? branch_addr : pc + pc_t'(`ICACHE_WORD_W / 8);

    // Replay re-reads the missed line, stage 1 keeps its PC
    assign rd_en    = advance | (proc_ready & (state == LK_REPLAY));
    assign rd_index = (state == LK_REPLAY) ? pc_index(pc_d1) : pc_index(pc);

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state   <= LK_RUN;
            pc      <= `ICACHE_RESET_PC;
            s2_vld  <= 1'b0;
            dv_q    <= 1'b0;
            valid_q <= '0;
        end else begin
            if (fill.wr)
                valid_q[fill.index] <= 1'b1;      // Not frozen, refill side
            if (proc_ready)
                dv_q <= cache_ready & s2_hit;
            if (advance) begin
                pc     <= next_pc;
                s2_vld <= 1'b1;
            end
            case (state)
                LK_RUN:    if (miss)       state <= LK_WAIT;
                LK_WAIT:   if (fill.wr)    state <= LK_REPLAY;
                LK_REPLAY: if (proc_ready) state <= LK_RUN;
                default:                   state <= LK_RUN;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stores, stage registers and output register
    //////////////////////////////////////////////////////////////////////

    assign s2_words = line_rd;

    always_ff @(posedge CLK) begin
        if (fill.wr) begin
            tag_mem[fill.index]  <= fill.tag;
            line_mem[fill.index] <= fill.line;
        end
        if (rd_en) begin
            tag_rd   <= tag_mem[rd_index];
            line_rd  <= line_mem[rd_index];
            valid_rd <= valid_q[rd_index];
        end
        if (advance)
            pc_d1 <= pc;
        if (advance & s2_hit) begin
            data_to_proc <= s2_words[pc_offset(pc_d1)];
            pc_to_proc   <= pc_d1;
        end
    end

endmodule

`default_nettype wire

/* refill/icache_refill.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_refill
    import icache_pkg::*;
    import l2_pkg::*;
(
    input  logic     CLK,
    input  logic     arst_n,
    input  logic     miss,
    input  pc_t      miss_pc,
    output logic     l2_addr_valid,
    input  logic     l2_addr_ready,
    output l2_addr_t l2_addr,
    input  logic     l2_data_valid,
    output logic     l2_data_ready,
    input  l2_data_t l2_data,
    line_fill_if.src fill
);

    refill_state_t           state;
    beat_cnt_t               beat_cnt;   // Next beat slot
    l2_data_t [L2_BEATS-1:0] line_buf;   // Line being assembled
    logic                    beat_take;
    logic                    last_beat;

    //////////////////////////////////////////////////////////////////////
    // Miss FSM
    //////////////////////////////////////////////////////////////////////

    // Not frozen by proc_ready, so L2 handshakes always complete
    assign beat_take = (state == COLLECT) & l2_data_valid;
    assign last_beat = beat_take & (beat_cnt == beat_cnt_t'(L2_BEATS - 1));

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (miss) begin
                        state    <= REQUEST;
                        beat_cnt <= '0;
                    end
                end
                REQUEST: begin
                    if (l2_addr_ready)
                        state <= COLLECT;       // Address accepted
                end
                COLLECT: begin
                    if (beat_take)
                        beat_cnt <= beat_cnt + 1'b1;
                    if (last_beat)
                        state <= WRITE;
                end
                WRITE: state <= IDLE;           // fill.wr high this cycle
                default: state <= IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Address register and beat assembly
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        // Loaded once per miss, stable through REQUEST
        if ((state == IDLE) && miss)
            l2_addr <= miss_pc[$bits(pc_t)-1 -: L2_ADDR_W];
        // Beats arrive lowest word first
        if (beat_take)
            line_buf[beat_cnt] <= l2_data;
    end

    assign l2_addr_valid = (state == REQUEST);
    assign l2_data_ready = (state == COLLECT);     // One request in flight

    // Line address is {tag, index}
    assign {fill.tag, fill.index} = l2_addr;
    assign fill.line = line_buf;
    assign fill.wr   = (state == WRITE);

endmodule

`default_nettype wire
